// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // SPECIAL function code, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_AND  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_ADD  = 4'd10,
        ALU_SUB  = 4'd11
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        word_t     imm;
        reg_addr_t wd;          // destination register
        logic      wreg;
    } dec_ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wr_port_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     reg1;
        word_t     reg2;
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire logic                clk_i,
    input  wire logic                arst_n_i,
    input  wire mips_pkg::wr_port_t  wr_i,
    input  wire mips_pkg::reg_addr_t raddr1_i,
    input  wire mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t          rdata1_o,
    output mips_pkg::word_t          rdata2_o
);

    mips_pkg::word_t regs [mips_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && (wr_i.addr != '0)) begin  // r0 never written
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
    input  wire logic            inst_valid_i,
    input  wire mips_pkg::word_t inst_i,
    output mips_pkg::dec_ctrl_t  ctrl_o
);

    mips_pkg::opcode_e   opcode;
    mips_pkg::funct_e    funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::reg_addr_t shamt;
    logic [15:0]         imm16;

    mips_pkg::alu_op_e   rtype_op;
    logic                shift_imm;
    logic                imm_form;
    logic                dec_ok;
    mips_pkg::dec_ctrl_t ctrl;

    assign opcode = mips_pkg::opcode_e'(inst_i[31:26]);
    assign funct  = mips_pkg::funct_e'(inst_i[5:0]);
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign imm16  = inst_i[15:0];

    // function code to alu op for the SPECIAL group
    always_comb begin
        rtype_op  = mips_pkg::ALU_NOP;
        shift_imm = 1'b0;
        case (funct)
            mips_pkg::FN_OR:   rtype_op = mips_pkg::ALU_OR;
            mips_pkg::FN_AND:  rtype_op = mips_pkg::ALU_AND;
            mips_pkg::FN_XOR:  rtype_op = mips_pkg::ALU_XOR;
            mips_pkg::FN_NOR:  rtype_op = mips_pkg::ALU_NOR;
            mips_pkg::FN_SLLV: rtype_op = mips_pkg::ALU_SLL;
            mips_pkg::FN_SRLV: rtype_op = mips_pkg::ALU_SRL;
            mips_pkg::FN_SRAV: rtype_op = mips_pkg::ALU_SRA;
            mips_pkg::FN_SLT:  rtype_op = mips_pkg::ALU_SLT;
            mips_pkg::FN_SLTU: rtype_op = mips_pkg::ALU_SLTU;
            mips_pkg::FN_ADD,
            mips_pkg::FN_ADDU: rtype_op = mips_pkg::ALU_ADD;  // no overflow trap
            mips_pkg::FN_SUB,
            mips_pkg::FN_SUBU: rtype_op = mips_pkg::ALU_SUB;
            mips_pkg::FN_SLL: begin
                rtype_op  = mips_pkg::ALU_SLL;
                shift_imm = 1'b1;
            end
            mips_pkg::FN_SRL: begin
                rtype_op  = mips_pkg::ALU_SRL;
                shift_imm = 1'b1;
            end
            mips_pkg::FN_SRA: begin
                rtype_op  = mips_pkg::ALU_SRA;
                shift_imm = 1'b1;
            end
            default: rtype_op = mips_pkg::ALU_NOP;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.alu_op    = mips_pkg::ALU_NOP;
        ctrl.reg1_addr = rs;
        ctrl.reg2_addr = rt;
        ctrl.wd        = rt;                // immediate forms write rt
        imm_form       = 1'b0;
        dec_ok         = 1'b0;

        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.wd = rd;
                if (shift_imm) begin
                    if (rs == '0) begin     // sll/srl/sra need rs field clear
                        ctrl.alu_op    = rtype_op;
                        ctrl.reg2_read = 1'b1;
                        ctrl.imm       = {{(mips_pkg::XLEN-mips_pkg::REG_ADDR_W){1'b0}}, shamt};
                        dec_ok         = 1'b1;
                    end
                end else if ((rtype_op != mips_pkg::ALU_NOP) && (shamt == '0)) begin
                    ctrl.alu_op    = rtype_op;
                    ctrl.reg1_read = 1'b1;
                    ctrl.reg2_read = 1'b1;
                    dec_ok         = 1'b1;
                end
            end
            mips_pkg::OP_ORI: begin
                ctrl.alu_op = mips_pkg::ALU_OR;
                ctrl.imm    = {16'h0, imm16};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_ANDI: begin
                ctrl.alu_op = mips_pkg::ALU_AND;
                ctrl.imm    = {16'h0, imm16};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_XORI: begin
                ctrl.alu_op = mips_pkg::ALU_XOR;
                ctrl.imm    = {16'h0, imm16};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                ctrl.alu_op = mips_pkg::ALU_OR;   // or'd with rs
                ctrl.imm    = {imm16, 16'h0};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_SLTI: begin
                ctrl.alu_op = mips_pkg::ALU_SLT;
                ctrl.imm    = {{16{imm16[15]}}, imm16};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_SLTIU: begin
                ctrl.alu_op = mips_pkg::ALU_SLTU;
                ctrl.imm    = {{16{imm16[15]}}, imm16};
                imm_form    = 1'b1;
            end
            mips_pkg::OP_ADDI,
            mips_pkg::OP_ADDIU: begin
                ctrl.alu_op = mips_pkg::ALU_ADD;
                ctrl.imm    = {{16{imm16[15]}}, imm16};
                imm_form    = 1'b1;
            end
            default: dec_ok = 1'b0;
        endcase

        if (imm_form) begin
            ctrl.reg1_read = 1'b1;          // rs only, imm goes to reg2
            dec_ok         = 1'b1;
        end

        ctrl.wreg = inst_valid_i && dec_ok && (ctrl.wd != '0);
    end

    assign ctrl_o = ctrl;

endmodule

`default_nettype wire

// ==== rtl/operand_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_select (
    input  wire mips_pkg::dec_ctrl_t ctrl_i,
    input  wire mips_pkg::word_t     rdata1_i,
    input  wire mips_pkg::word_t     rdata2_i,
    input  wire mips_pkg::wr_port_t  ex_fwd_i,
    input  wire mips_pkg::wr_port_t  mem_fwd_i,
    output mips_pkg::word_t          reg1_o,
    output mips_pkg::word_t          reg2_o
);

    // newest producer wins, then regfile, else immediate
    function automatic mips_pkg::word_t pick_operand(
        input logic                rd_en,
        input mips_pkg::reg_addr_t addr,
        input mips_pkg::word_t     rdata,
        input mips_pkg::word_t     imm,
        input mips_pkg::wr_port_t  ex_fwd,
        input mips_pkg::wr_port_t  mem_fwd
    );
        mips_pkg::word_t val;
        if (!rd_en) begin
            val = imm;
        end else if (ex_fwd.we && (ex_fwd.addr == addr)) begin
            val = ex_fwd.data;
        end else if (mem_fwd.we && (mem_fwd.addr == addr)) begin
            val = mem_fwd.data;
        end else begin
            val = rdata;
        end
        return val;
    endfunction

    assign reg1_o = pick_operand(ctrl_i.reg1_read, ctrl_i.reg1_addr, rdata1_i,
                                 ctrl_i.imm, ex_fwd_i, mem_fwd_i);
    assign reg2_o = pick_operand(ctrl_i.reg2_read, ctrl_i.reg2_addr, rdata2_i,
                                 ctrl_i.imm, ex_fwd_i, mem_fwd_i);

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire mips_pkg::id_ex_t op_i,
    output mips_pkg::word_t       result_o
);

    mips_pkg::word_t reg1;
    mips_pkg::word_t reg2;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign reg1  = op_i.reg1;
    assign reg2  = op_i.reg2;
    assign shamt = reg1[4:0];               // shift amount from reg1

    assign lt_signed   = $signed(reg1) < $signed(reg2);
    assign lt_unsigned = reg1 < reg2;

    always_comb begin
        case (op_i.alu_op)
            mips_pkg::ALU_OR:   result_o = reg1 | reg2;
            mips_pkg::ALU_AND:  result_o = reg1 & reg2;
            mips_pkg::ALU_XOR:  result_o = reg1 ^ reg2;
            mips_pkg::ALU_NOR:  result_o = ~(reg1 | reg2);
            mips_pkg::ALU_SLL:  result_o = reg2 << shamt;
            mips_pkg::ALU_SRL:  result_o = reg2 >> shamt;
            mips_pkg::ALU_SRA:  result_o = mips_pkg::word_t'($signed(reg2) >>> shamt);
            mips_pkg::ALU_SLT:  result_o = {{(mips_pkg::XLEN-1){1'b0}}, lt_signed};
            mips_pkg::ALU_SLTU: result_o = {{(mips_pkg::XLEN-1){1'b0}}, lt_unsigned};
            mips_pkg::ALU_ADD:  result_o = reg1 + reg2;
            mips_pkg::ALU_SUB:  result_o = reg1 - reg2;
            default:            result_o = '0;  // nop
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module mips_core (
    input  wire logic            clk_i,
    input  wire logic            arst_n_i,
    input  wire logic            inst_valid_i,
    input  wire mips_pkg::word_t inst_i,
    output mips_pkg::wr_port_t   wb_o
);

    mips_pkg::dec_ctrl_t dec_ctrl;
    mips_pkg::word_t     rdata1;
    mips_pkg::word_t     rdata2;
    mips_pkg::word_t     opnd1;
    mips_pkg::word_t     opnd2;

    mips_pkg::id_ex_t    id_ex_d;
    mips_pkg::id_ex_t    id_ex_q;
    mips_pkg::word_t     alu_result;
    mips_pkg::wr_port_t  ex_fwd;
    mips_pkg::wr_port_t  mem_fwd;           // execute/memory register

    inst_decode u_decode (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .ctrl_o       (dec_ctrl)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wr_i     (mem_fwd),
        .raddr1_i (dec_ctrl.reg1_addr),
        .raddr2_i (dec_ctrl.reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_select u_opsel (
        .ctrl_i    (dec_ctrl),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .reg1_o    (opnd1),
        .reg2_o    (opnd2)
    );

    always_comb begin
        id_ex_d.alu_op = dec_ctrl.alu_op;
        id_ex_d.reg1   = opnd1;
        id_ex_d.reg2   = opnd2;
        id_ex_d.wd     = dec_ctrl.wd;
        id_ex_d.wreg   = dec_ctrl.wreg;     // low for bubbles
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    alu u_alu (
        .op_i     (id_ex_q),
        .result_o (alu_result)
    );

    assign ex_fwd.we   = id_ex_q.wreg;
    assign ex_fwd.addr = id_ex_q.wd;
    assign ex_fwd.data = alu_result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_fwd <= '0;
        end else begin
            mem_fwd <= ex_fwd;
        end
    end

    // same value writes the regfile on the next edge
    assign wb_o = mem_fwd;

endmodule

`default_nettype wire

// ==== verif/tb_mips_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    localparam int          MAX_VECS = 64;
    localparam int          FIELDS   = 4;           // inst, we, addr, data
    localparam int unsigned SEED     = 32'h3294b079;

    typedef struct packed {
        logic               chk;
        mips_pkg::wr_port_t exp;
    } slot_t;

    logic               clk_i;
    logic               arst_n_i;
    logic               inst_valid_i;
    mips_pkg::word_t    inst_i;
    mips_pkg::wr_port_t wb_o;

    logic [31:0] vec_mem [0:MAX_VECS*FIELDS];
    slot_t       slot_q [$];                        // one entry per driven cycle
    int          num_vecs;
    int          errors;
    logic        vecs_loaded;

    mips_core UUT (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_o         (wb_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic drive_idle();
        slot_t s;
        s = '0;
        @(posedge clk_i);
        inst_valid_i <= 1'b0;
        inst_i       <= $urandom();                 // junk while not valid
        slot_q.push_back(s);
    endtask

    task automatic drive_inst(input int idx);
        slot_t s;
        int    base;
        base       = 1 + idx * FIELDS;
        s.chk      = 1'b1;
        s.exp.we   = vec_mem[base+1][0];
        s.exp.addr = vec_mem[base+2][4:0];
        s.exp.data = vec_mem[base+3];
        @(posedge clk_i);
        inst_valid_i <= 1'b1;
        inst_i       <= vec_mem[base];
        slot_q.push_back(s);
    endtask

    task automatic check_slot(input slot_t s);
        logic exp_we;
        exp_we = s.chk && s.exp.we;
        assert (wb_o.we == exp_we) else begin
            errors++;
            $display("mismatch at %0t: wb_o.we expected %0b actual %0b",
                     $time, exp_we, wb_o.we);
        end
        if (exp_we) begin
            assert (wb_o.addr == s.exp.addr) else begin
                errors++;
                $display("mismatch at %0t: wb_o.addr expected %0d actual %0d",
                         $time, s.exp.addr, wb_o.addr);
            end
            assert (wb_o.data == s.exp.data) else begin
                errors++;
                $display("mismatch at %0t: wb_o.data expected %08h actual %08h",
                         $time, s.exp.data, wb_o.data);
            end
        end
    endtask

    // driven at edge k, sampled at k+1, on wb_o after k+2
    always @(negedge clk_i) begin
        slot_t s;
        s = '0;
        if (arst_n_i) begin
            if (slot_q.size() > 2) begin
                s = slot_q.pop_front();
            end
            check_slot(s);                          // empty slot means we low
        end
    end

    initial begin
        int unsigned seed_ret;
        int unsigned gap;
        int          idx;
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        errors       = 0;
        vecs_loaded  = 1'b0;
        seed_ret     = $urandom(SEED);
        $readmemh("verif/mips_core_vectors.txt", vec_mem);
        num_vecs     = int'(vec_mem[0]);
        vecs_loaded  = 1'b1;

        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;

        if ((num_vecs < 1) || (num_vecs > MAX_VECS)) begin
            errors++;
            $display("vector file holds a bad vector count (%0d)", num_vecs);
        end else begin
            for (idx = 0; idx < num_vecs; idx++) begin
                gap = $urandom_range(2, 0);
                repeat (gap) drive_idle();
                drive_inst(idx);
            end
            repeat (4) drive_idle();                // drain
        end

        $display("run done: %0d vectors, %0d errors", num_vecs, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (vecs_loaded === 1'b1);
        #((num_vecs * 4 + 20) * 10);
        $display("timeout: writeback checks did not finish, %0d errors so far", errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_core.f ====
rtl/mips_pkg.sv
rtl/regfile.sv
rtl/inst_decode.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/mips_core.sv
verif/tb_mips_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips_core \
    -f mips_core.f -o Vtb_mips_core

sim_out=$(./obj_dir/Vtb_mips_core)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// ==== verif/mips_core_vectors.txt ====
// first word: vector count; then per line: inst word, expected we, expected addr,
// expected data (addr and data are not checked when we is 0)
25
34011234 1 01 00001234  // ori   r1, r0, 0x1234
3c02ffff 1 02 ffff0000  // lui   r2, 0xffff
2003fffb 1 03 fffffffb  // addi  r3, r0, -5
3824ff00 1 04 0000ed34  // xori  r4, r1, 0xff00
30658fff 1 05 00008ffb  // andi  r5, r3, 0x8fff
24a6ffff 1 06 00008ffa  // addiu r6, r5, -1
00223825 1 07 ffff1234  // or    r7, r1, r2
00e44024 1 08 00000034  // and   r8, r7, r4
00e34826 1 09 0000edcf  // xor   r9, r7, r3
00205027 1 0a ffffedcb  // nor   r10, r1, r0
00615820 1 0b 0000122f  // add   r11, r3, r1
016b6021 1 0c 0000245e  // addu  r12, r11, r11
00236822 1 0d 00001239  // sub   r13, r1, r3
00017023 1 0e ffffedcc  // subu  r14, r0, r1
0061782a 1 0f 00000001  // slt   r15, r3, r1
0061802b 1 10 00000000  // sltu  r16, r3, r1
00018900 1 11 00012340  // sll   r17, r1, 4
00029202 1 12 00ffff00  // srl   r18, r2, 8
00029a03 1 13 ffffff00  // sra   r19, r2, 8
34140024 1 14 00000024  // ori   r20, r0, 0x24
0281a804 1 15 00012340  // sllv  r21, r1, r20
0283b007 1 16 ffffffff  // srav  r22, r3, r20
0283b806 1 17 0fffffff  // srlv  r23, r3, r20
24180001 1 18 00000001  // addiu r24, r0, 1
0318c021 1 18 00000002  // addu  r24, r24, r24
0318c021 1 18 00000004  // addu  r24, r24, r24
0018c880 1 19 00000010  // sll   r25, r24, 2
0338d023 1 1a 0000000c  // subu  r26, r25, r24
2b5b000d 1 1b 00000001  // slti  r27, r26, 13
2c7cfffc 1 1c 00000001  // sltiu r28, r3, -4
3c3dabcd 1 1d abcd1234  // lui   r29, 0xabcd with rs r1
00220025 0 00 00000000  // or    r0, r1, r2
00000000 0 00 00000000  // all-zero word
8c250004 0 00 00000000  // lw, not decoded
00221801 0 00 00000000  // SPECIAL funct 0x01, not decoded
0005f021 1 1e 00008ffb  // addu  r30, r0, r5
0040f825 1 1f ffff0000  // or    r31, r2, r0
